/* src.f */
+incdir+.
starkPkg.sv
starkDecodeMacro.sv
starkMacroExpander.sv
starkDecodeRegs.sv
starkDecodeTop.sv
starkDecodeTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode front end testbench with Verilator and runs it
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
	-f src.f \
	--top-module starkDecodeTb \
	-o starkDecodeSim

./obj_dir/starkDecodeSim | tee sim.log

if grep -qF "*** TEST PASSED ***" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

/* starkDecodeTb.sv */
// Stark decode front end testbench with LFSR stimulus, a reference model and a micro-op checker
`timescale 1ns/10ps
`include "starkMacros.svh"

module starkDecodeTb;

localparam int MaskW = `STARK_MASK_W;
localparam int RegW = `STARK_REG_W;
localparam int OfsW = `STARK_OFS_W;
// Run limit for 400 instructions at about half rate on uopReady with margin
localparam int MaxCycles = 4000;

logic clk;
logic rstN;
logic instValid;
logic instReady;
logic uopValid;
logic uopReady;
starkPkg::instruction_t inst;
starkPkg::microOp_t uop;
starkPkg::apbReq_t apbReq;
starkPkg::apbRsp_t apbRsp;

// Expected micro-ops in transfer order
starkPkg::microOp_t expQ[$];
logic [31:0] lfsrState = 32'h68f8_c732;
int errors = 0;
int cycles = 0;
int instCount = 0;
int uopCount = 0;
int macroCount = 0;
logic wasStalled = 1'b0;
starkPkg::microOp_t heldUop;

starkDecodeTop UUT
(
	.clk       (clk),
	.rstN      (rstN),
	.instValid (instValid),
	.inst      (inst),
	.instReady (instReady),
	.uopValid  (uopValid),
	.uop       (uop),
	.uopReady  (uopReady),
	.apbReq    (apbReq),
	.apbRsp    (apbRsp)
);

// 40 ns period
always #20 clk = ~clk;

// ============================================================
// Random source and reference model
// ============================================================

// Fibonacci LFSR with taps 32, 22, 2 and 1
function automatic logic [31:0] lfsrNext(input logic [31:0] s);
	return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One LFSR step per bit with the newest bit landing in bit 0
function automatic logic [31:0] takeBits(input int n);
	logic [31:0] bits;
	bits = '0;
	for (int b = 0; b < n; b++)
	begin
		lfsrState = lfsrNext(lfsrState);
		bits = {bits[30:0], lfsrState[0]};
	end
	return bits;
endfunction

function automatic logic isStackOp(input starkPkg::instruction_t ir);
	return (ir.any.opcode == starkPkg::OP_PUSH) || (ir.any.opcode == starkPkg::OP_POP);
endfunction

// Appends the micro-ops that one accepted instruction must produce
function automatic void modelMicroOps(input starkPkg::instruction_t ir, input logic enable);
	starkPkg::microOp_t m;
	int k;
	logic isPush;
	k = 0;
	isPush = (ir.any.opcode == starkPkg::OP_PUSH);
	m.inst = ir;
	m.regNum = '0;
	m.offset = '0;
	if (!isStackOp(ir))
	begin
		m.kind = starkPkg::UOP_PASS;
		m.regNum = ir.any.rd;
		expQ.push_back(m);
	end
	else if (!enable)
	begin
		m.kind = starkPkg::UOP_ILLEGAL;
		expQ.push_back(m);
	end
	else
	begin
		// Set mask bits go in ascending order
		// k counts the slots used so far
		for (int i = 0; i < MaskW; i++)
		begin
			if (ir.stack.regMask[i])
			begin
				m.kind = isPush ? starkPkg::UOP_STORE : starkPkg::UOP_LOAD;
				m.regNum = ir.stack.regBase + RegW'(i);
				m.offset = isPush ? OfsW'(-(k + 1) * `STARK_SLOT_BYTES)
					: OfsW'(k * `STARK_SLOT_BYTES);
				expQ.push_back(m);
				k++;
			end
		end
		m.kind = starkPkg::UOP_ADDSP;
		m.regNum = '0;
		m.offset = isPush ? OfsW'(-k * `STARK_SLOT_BYTES) : OfsW'(k * `STARK_SLOT_BYTES);
		expQ.push_back(m);
	end
endfunction

// Random word where about one in four is a PUSH or POP
// The first four of a directed run cover empty and full masks
function automatic starkPkg::instruction_t makeInst(input int idx, input logic directed);
	starkPkg::instruction_t ir;
	logic [31:0] fields;
	logic [31:0] sel;
	logic [6:0] opc;
	fields = takeBits(25);
	sel = takeBits(3);
	if (directed && idx < 4)
		opc = idx[0] ? starkPkg::OP_POP : starkPkg::OP_PUSH;
	else if (sel[1:0] == 2'b00)
		opc = sel[2] ? starkPkg::OP_POP : starkPkg::OP_PUSH;
	else
	begin
		sel = takeBits(3);
		case (sel[2:0])
			3'd0: opc = starkPkg::OP_LOAD;
			3'd1: opc = starkPkg::OP_ALUI;
			3'd2: opc = starkPkg::OP_STORE;
			3'd3: opc = starkPkg::OP_LUI;
			3'd4: opc = starkPkg::OP_BRANCH;
			3'd5: opc = starkPkg::OP_JAL;
			default: opc = starkPkg::OP_ALU;
		endcase
	end
	ir = {fields[24:0], opc};
	if (directed && idx < 4)
		ir.stack.regMask = (idx == 1 || idx == 2) ? 8'hFF : 8'h00;
	return ir;
endfunction

// ============================================================
// Checker and timeout
// ============================================================

always @(posedge clk)
begin
	cycles++;
	if (cycles >= MaxCycles)
	begin
		$display("Timeout after %0d cycles with the test still running", cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end
end

// Output must hold while stalled
// Each transfer must match the next expected micro-op
always @(posedge clk)
begin
	starkPkg::microOp_t exp;
	if (rstN)
	begin
		if (wasStalled && !uopValid)
		begin
			$display("uopValid dropped while the sink was stalling it");
			errors++;
		end
		else if (wasStalled && uop != heldUop)
		begin
			$display("Fail uop held stable expected %h got %h", heldUop, uop);
			errors++;
		end
		wasStalled = uopValid && !uopReady;
		heldUop = uop;
		if (uopValid && uopReady)
		begin
			uopCount++;
			if (expQ.size() == 0)
			begin
				$display("A micro-op came out when none was expected");
				errors++;
			end
			else
			begin
				exp = expQ.pop_front();
				if (uop.kind != exp.kind)
				begin
					$display("Fail uop.kind expected %h got %h", exp.kind, uop.kind);
					errors++;
				end
				if (uop.regNum != exp.regNum)
				begin
					$display("Fail uop.regNum expected %h got %h", exp.regNum, uop.regNum);
					errors++;
				end
				if (uop.offset != exp.offset)
				begin
					$display("Fail uop.offset expected %h got %h", exp.offset, uop.offset);
					errors++;
				end
				if (uop.inst != exp.inst)
				begin
					$display("Fail uop.inst expected %h got %h", exp.inst, uop.inst);
					errors++;
				end
			end
		end
	end
end

// Mid-cycle the queue holds every micro-op not yet transferred
// A new word fits only when none is left or the single one in the output leaves now
always @(negedge clk)
begin
	logic expReady;
	if (rstN)
	begin
		expReady = (expQ.size() == 0) || (expQ.size() == 1 && uopReady);
		if (instReady != expReady)
		begin
			$display("Fail instReady expected %h got %h", expReady, instReady);
			errors++;
		end
	end
end

// ============================================================
// Stimulus tasks entered and left 2 ns after an edge
// ============================================================

// Sends count instructions, holding each word until it transfers
task automatic runStream(input int count, input logic enable, input logic directed);
	int sent;
	logic accepted;
	logic [31:0] bits;
	sent = 0;
	while (sent < count)
	begin
		@(posedge clk);
		accepted = instValid && instReady;
		if (accepted)
		begin
			modelMicroOps(inst, enable);
			instCount++;
			if (isStackOp(inst))
				macroCount++;
			sent++;
		end
		#2;
		bits = takeBits(1);
		uopReady = bits[0];
		if (!instValid || accepted)
		begin
			bits = takeBits(2);
			if (sent < count && bits[1:0] != 2'b00)
			begin
				inst = makeInst(sent, directed);
				instValid = 1'b1;
			end
			else
				instValid = 1'b0;
		end
	end
endtask

// Lets the output run dry and reports anything the DUT never produced
task automatic drainOutput();
	logic [31:0] bits;
	while (uopValid)
	begin
		@(posedge clk);
		#2;
		bits = takeBits(1);
		uopReady = bits[0];
	end
	if (expQ.size() != 0)
	begin
		$display("%0d expected micro-ops never came out of the DUT", expQ.size());
		errors++;
	end
endtask

task automatic apbAccess(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
	output logic [31:0] rdata, output logic err);
	apbReq = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
	@(posedge clk);
	#2;
	apbReq.penable = 1'b1;
	@(posedge clk);
	rdata = apbRsp.prdata;
	err = apbRsp.pslverr;
	// Every access completes with zero wait states
	if (apbRsp.pready !== 1'b1)
	begin
		$display("Fail apbRsp.pready at %h expected %h got %h", addr, 1'b1, apbRsp.pready);
		errors++;
	end
	#2;
	apbReq = '0;
endtask

// Reads one register and checks its value and error flag
task automatic apbCheck(input logic [7:0] addr, input logic [31:0] expData, input logic expErr);
	logic [31:0] rdata;
	logic err;
	apbAccess(1'b0, addr, 32'h0, rdata, err);
	if (rdata != expData)
	begin
		$display("Fail apbRsp.prdata at %h expected %h got %h", addr, expData, rdata);
		errors++;
	end
	if (err != expErr)
	begin
		$display("Fail apbRsp.pslverr at %h expected %h got %h", addr, expErr, err);
		errors++;
	end
endtask

initial
begin
	logic [31:0] rdata;
	logic err;
	clk = 1'b0;
	rstN = 1'b0;
	instValid = 1'b0;
	inst = '0;
	uopReady = 1'b0;
	apbReq = '0;
	repeat (2) @(posedge clk);
	#2;
	rstN = 1'b1;
	apbCheck(`STARK_ADDR_CTRL, 32'h1, 1'b0);
	// Expansion on with the directed masks first
	runStream(300, 1'b1, 1'b1);
	drainOutput();
	// Expansion off so stack instructions must trap
	apbAccess(1'b1, `STARK_ADDR_CTRL, 32'h0, rdata, err);
	apbCheck(`STARK_ADDR_CTRL, 32'h0, 1'b0);
	runStream(100, 1'b0, 1'b0);
	drainOutput();
	apbCheck(`STARK_ADDR_INSTCNT, instCount, 1'b0);
	apbCheck(`STARK_ADDR_UOPCNT, uopCount, 1'b0);
	apbCheck(`STARK_ADDR_MACROCNT, macroCount, 1'b0);
	apbCheck(8'h10, 32'h0, 1'b1);
	$display("Errors %0d, instructions %0d, micro-ops %0d, macros %0d",
		errors, instCount, uopCount, macroCount);
	if (errors == 0)
		$display("*** TEST PASSED ***");
	else
		$display("*** TEST FAILED ***");
	$finish;
end

endmodule

/* starkDecodeTop.sv */
// Stark decode front end top level joining macro detection, expansion and registers
`timescale 1ns/10ps

module starkDecodeTop
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instValid,
	input  starkPkg::instruction_t inst,
	output logic                   instReady,
	output logic                   uopValid,
	output starkPkg::microOp_t     uop,
	input  logic                   uopReady,
	input  starkPkg::apbReq_t      apbReq,
	output starkPkg::apbRsp_t      apbRsp
);

// Detector to expander
logic macroFlag;
// Register block to expander
logic macroEnable;
// Expander event pulses to the counters
logic instTaken;
logic uopTaken;
logic macroTaken;

// Classifies the word at the input port
starkDecodeMacro macroDet
(
	.inst        (inst),
	.macro       (macroFlag)
);

// Owns both handshakes and the output register
starkMacroExpander expander
(
	.clk         (clk),
	.rstN        (rstN),
	.instValid   (instValid),
	.inst        (inst),
	.macro       (macroFlag),
	.macroEnable (macroEnable),
	.instReady   (instReady),
	.uopValid    (uopValid),
	.uop         (uop),
	.uopReady    (uopReady),
	.instTaken   (instTaken),
	.uopTaken    (uopTaken),
	.macroTaken  (macroTaken)
);

// Control and statistics on the APB port
starkDecodeRegs regs
(
	.clk         (clk),
	.rstN        (rstN),
	.apbReq      (apbReq),
	.apbRsp      (apbRsp),
	.instTaken   (instTaken),
	.uopTaken    (uopTaken),
	.macroTaken  (macroTaken),
	.macroEnable (macroEnable)
);

endmodule

/* starkDecodeRegs.sv */
// Stark decode APB register block with the macro enable bit and three event counters
`timescale 1ns/10ps
`include "starkMacros.svh"

module starkDecodeRegs
(
	input  logic              clk,
	input  logic              rstN,
	input  starkPkg::apbReq_t apbReq,
	output starkPkg::apbRsp_t apbRsp,
	input  logic              instTaken,
	input  logic              uopTaken,
	input  logic              macroTaken,
	output logic              macroEnable
);

localparam int CntW = `STARK_CNT_W;
localparam int NumCnt = 3;
// Slot of each event in the counter array
localparam int CntInst = 0;
localparam int CntUop = 1;
localparam int CntMacro = 2;

logic access;
logic wrCtrl;
logic ctrlEnable;
logic mapped;
logic [CntW-1:0] rdData;
logic [NumCnt-1:0] evtPulse;
logic [CntW-1:0] evtCnt [NumCnt];

// ============================================================
// Access decode
// ============================================================

// Zero wait states so the access phase is the only cycle that matters
assign access = apbReq.psel && apbReq.penable;
assign wrCtrl = access && apbReq.pwrite && (apbReq.paddr == `STARK_ADDR_CTRL);

// Pulses packed in counter order
assign evtPulse = {macroTaken, uopTaken, instTaken};

// ============================================================
// Control register
// ============================================================

// Expansion comes up enabled
// Only bit 0 is stored and the rest read back as zero
always_ff @(posedge clk)
begin
	if (!rstN)
		ctrlEnable <= 1'b1;
	else if (wrCtrl)
		ctrlEnable <= apbReq.pwdata[0];
end

assign macroEnable = ctrlEnable;

// ============================================================
// Event counters
// ============================================================

// Free running and wrapping, writes from the bus never reach them
always_ff @(posedge clk)
begin
	for (int e = 0; e < NumCnt; e++)
	begin
		if (!rstN)
			evtCnt[e] <= '0;
		else if (evtPulse[e])
			evtCnt[e] <= evtCnt[e] + 1'b1;
	end
end

// ============================================================
// Read path
// ============================================================

// Reads see register contents from the previous edge
always_comb
begin
	rdData = '0;
	mapped = 1'b1;
	case (apbReq.paddr)
		`STARK_ADDR_CTRL:
			rdData = CntW'(ctrlEnable);
		`STARK_ADDR_INSTCNT:
			rdData = evtCnt[CntInst];
		`STARK_ADDR_UOPCNT:
			rdData = evtCnt[CntUop];
		`STARK_ADDR_MACROCNT:
			rdData = evtCnt[CntMacro];
		default:
			mapped = 1'b0;
	endcase
end

// Unmapped addresses read as zero and flag an error in the access phase
always_comb
begin
	apbRsp.prdata = rdData;
	apbRsp.pready = 1'b1;
	apbRsp.pslverr = access && !mapped;
end

endmodule

/* starkMacroExpander.sv */
// Stark macro expander that sequences PUSH and POP into store, load and stack micro-ops
`timescale 1ns/10ps
`include "starkMacros.svh"

module starkMacroExpander
(
	input  logic                   clk,
	input  logic                   rstN,
	input  logic                   instValid,
	input  starkPkg::instruction_t inst,
	input  logic                   macro,
	input  logic                   macroEnable,
	output logic                   instReady,
	output logic                   uopValid,
	output starkPkg::microOp_t     uop,
	input  logic                   uopReady,
	output logic                   instTaken,
	output logic                   uopTaken,
	output logic                   macroTaken
);

localparam int RegW = `STARK_REG_W;
localparam int MaskW = `STARK_MASK_W;
localparam int OfsW = `STARK_OFS_W;
localparam int IdxW = $clog2(`STARK_MASK_W);
// One extra bit so the slot index can reach the full mask count
localparam int SlotW = IdxW + 1;

// Expansion state kept between micro-ops
logic busy;
logic [MaskW-1:0] remMask;
logic [SlotW-1:0] slotK;
starkPkg::instruction_t savedInst;

// Generator inputs and results
logic [MaskW-1:0] genMask;
logic [SlotW-1:0] genK;
starkPkg::instruction_t genInst;
logic genPush;
logic [IdxW-1:0] genIdx;
logic [OfsW-1:0] kOfs;
logic [OfsW-1:0] kNextOfs;
starkPkg::microOp_t genUop;
starkPkg::microOp_t firstUop;
logic step;

// Index of the lowest set bit, zero for an empty mask
function automatic logic [IdxW-1:0] lowestBit(input logic [MaskW-1:0] m);
	logic [IdxW-1:0] idx;
	idx = '0;
	for (int b = MaskW - 1; b >= 0; b--)
		if (m[b])
			idx = IdxW'(b);
	return idx;
endfunction

// ============================================================
// Handshakes and event pulses
// ============================================================

// New words only enter when no expansion is pending and the output register frees up
assign instReady = !busy && (!uopValid || uopReady);
assign instTaken = instValid && instReady;
assign uopTaken = uopValid && uopReady;
// Disabled macros still count as macros seen
assign macroTaken = instTaken && macro;

// The generator advances on acceptance of an enabled macro
// and afterwards on every transfer until the stack adjustment goes out
assign step = busy ? uopTaken : (instTaken && macro && macroEnable);

// ============================================================
// Micro-op generator
// ============================================================

always_comb
begin
	// While busy work from the latched copy, otherwise from the arriving word
	genMask = busy ? remMask : inst.stack.regMask;
	genK = busy ? slotK : '0;
	genInst = busy ? savedInst : inst;
	genPush = (genInst.any.opcode == starkPkg::OP_PUSH);
	genIdx = lowestBit(genMask);
	// Byte distance of slot k and of slot k+1
	kOfs = OfsW'(genK) * OfsW'(`STARK_SLOT_BYTES);
	kNextOfs = kOfs + OfsW'(`STARK_SLOT_BYTES);
	genUop.inst = genInst;
	if (genMask != '0)
	begin
		// PUSH stores below the stack pointer, POP loads from it upward
		genUop.kind = genPush ? starkPkg::UOP_STORE : starkPkg::UOP_LOAD;
		genUop.regNum = genInst.stack.regBase + RegW'(genIdx);
		genUop.offset = $signed(genPush ? -kNextOfs : kOfs);
	end
	else
	begin
		// Mask used up so k now equals the number of registers moved
		genUop.kind = starkPkg::UOP_ADDSP;
		genUop.regNum = '0;
		genUop.offset = $signed(genPush ? -kOfs : kOfs);
	end
end

// First micro-op of a freshly accepted word
always_comb
begin
	if (!macro)
	begin
		firstUop.kind = starkPkg::UOP_PASS;
		firstUop.regNum = inst.any.rd;
		firstUop.offset = '0;
		firstUop.inst = inst;
	end
	else if (!macroEnable)
	begin
		// Stack instructions trap when expansion is switched off
		firstUop.kind = starkPkg::UOP_ILLEGAL;
		firstUop.regNum = '0;
		firstUop.offset = '0;
		firstUop.inst = inst;
	end
	else
		firstUop = genUop;
end

// ============================================================
// State and output register
// ============================================================

always_ff @(posedge clk)
begin
	if (!rstN)
	begin
		uopValid <= 1'b0;
		busy <= 1'b0;
		remMask <= '0;
		slotK <= '0;
	end
	else
	begin
		if (instTaken)
			uopValid <= 1'b1;
		else if (uopTaken)
			uopValid <= busy;
		if (step)
		begin
			// Stay busy while a store or load goes out since the adjustment follows it
			busy <= (genMask != '0);
			remMask <= genMask & (genMask - MaskW'(1));
			slotK <= genK + SlotW'(1);
		end
	end
end

// Payload holds while stalled and reloads only on acceptance or advance
always_ff @(posedge clk)
begin
	if (instTaken)
	begin
		uop <= firstUop;
		savedInst <= inst;
	end
	else if (busy && uopTaken)
		uop <= genUop;
end

endmodule

/* starkDecodeMacro.sv */
// Stark macro detector that flags PUSH and POP instruction words
`timescale 1ns/10ps

module starkDecodeMacro
(
	input  starkPkg::instruction_t inst,
	output logic                   macro
);

// Decides which opcodes get expanded into several micro-ops
// Only the stack instructions are macros in this core
function automatic logic fnIsMacro(input starkPkg::instruction_t ir);
	logic isMacro;
	case (ir.any.opcode)
		starkPkg::OP_PUSH,
		starkPkg::OP_POP:
			isMacro = 1'b1;
		default:
			isMacro = 1'b0;
	endcase
	return isMacro;
endfunction

// The opcode sits at the same place in every format
// so the general view is enough to classify the word
always_comb
begin
	macro = fnIsMacro(inst);
end

endmodule

/* starkPkg.sv */
// Stark decode types for opcodes, instruction formats, micro-ops and the APB port
`include "starkMacros.svh"

package starkPkg;

	// ============================================================
	// Opcodes
	// ============================================================

	// Seven bit major opcode in the low bits of every instruction
	// PUSH and POP sit in the custom opcode space of the encoding
	typedef enum logic [6:0]
	{
		OP_LOAD   = 7'h03,
		OP_PUSH   = 7'h0B,
		OP_ALUI   = 7'h13,
		OP_STORE  = 7'h23,
		OP_POP    = 7'h2B,
		OP_ALU    = 7'h33,
		OP_LUI    = 7'h37,
		OP_BRANCH = 7'h63,
		OP_JAL    = 7'h6F
	} opcode_t;

	// ============================================================
	// Instruction formats
	// ============================================================

	// General format used by every non-stack instruction
	// Opcode in bits 6:0, rd in 11:7, rs1 in 16:12 and the immediate above
	typedef struct packed
	{
		logic [14:0]               imm;
		logic [`STARK_REG_W-1:0]   rs1;
		logic [`STARK_REG_W-1:0]   rd;
		opcode_t                   opcode;
	} instAny_t;

	// Stack format shared by PUSH and POP
	// regMask in bits 14:7 selects registers counted up from regBase in 19:15
	typedef struct packed
	{
		logic [11:0]               spare;
		logic [`STARK_REG_W-1:0]   regBase;
		logic [`STARK_MASK_W-1:0]  regMask;
		opcode_t                   opcode;
	} instStack_t;

	// The same word read through either format
	// The opcode lands in bits 6:0 in both views
	typedef union packed
	{
		instAny_t   any;
		instStack_t stack;
	} instruction_t;

	// ============================================================
	// Micro-ops
	// ============================================================

	// Kinds of micro-op leaving the decoder
	typedef enum logic [2:0]
	{
		UOP_PASS    = 3'd0,
		UOP_STORE   = 3'd1,
		UOP_LOAD    = 3'd2,
		UOP_ADDSP   = 3'd3,
		UOP_ILLEGAL = 3'd4
	} uopKind_t;

	// One micro-op with its register, stack offset and the instruction it came from
	typedef struct packed
	{
		uopKind_t                        kind;
		logic [`STARK_REG_W-1:0]         regNum;
		logic signed [`STARK_OFS_W-1:0]  offset;
		instruction_t                    inst;
	} microOp_t;

	// ============================================================
	// APB
	// ============================================================

	// Requester side of the register port
	typedef struct packed
	{
		logic                     psel;
		logic                     penable;
		logic                     pwrite;
		logic [7:0]               paddr;
		logic [`STARK_CNT_W-1:0]  pwdata;
	} apbReq_t;

	// Completer side of the register port
	typedef struct packed
	{
		logic [`STARK_CNT_W-1:0]  prdata;
		logic                     pready;
		logic                     pslverr;
	} apbRsp_t;

endpackage

/* starkMacros.svh */
// Stark decode front end widths, stack slot size and APB register offsets
`ifndef STARK_MACROS_SVH
`define STARK_MACROS_SVH

// Instruction word width
`define STARK_INSTR_W 32

// Register index width gives a file of 32 registers
`define STARK_REG_W 5

// PUSH and POP carry one mask bit per register in the run
`define STARK_MASK_W 8

// Every register takes one slot of this many bytes on the stack
`define STARK_SLOT_BYTES 8

// Micro-op offsets are signed byte distances from the stack pointer
`define STARK_OFS_W 16

// Event counters wrap at this width
`define STARK_CNT_W 32

// APB register map in bytes
`define STARK_ADDR_CTRL 8'h00
`define STARK_ADDR_INSTCNT 8'h04
`define STARK_ADDR_UOPCNT 8'h08
`define STARK_ADDR_MACROCNT 8'h0C

`endif
